//--- design/audio_ctrl_pkg.sv
`default_nettype none

package audio_ctrl_pkg;

    // ==========================================================================
    // Host protocol
    // ==========================================================================

    // One byte as it moves through the host FIFOs
    typedef logic [7:0] byte_t;

    // Command in header bits 7..6
    typedef enum logic [1:0] {
        CMD_SETUP_OUTPUT  = 2'd0,
        CMD_SETUP_INPUT   = 2'd1,
        CMD_STREAM_OUTPUT = 2'd2,
        // Also sent back as the "stopped" command in every reply
        CMD_STOP          = 2'd3
    } cmd_t;

    // Payload byte count in header bits 5..0
    typedef logic [5:0] payload_len_t;

    // Only legal lengths for the commands that are checked
    localparam payload_len_t SETUP_PAYLOAD_LEN = 6'd1;
    localparam payload_len_t STOP_PAYLOAD_LEN  = 6'd0;

    // Reply carries a single status byte, so its header is C1
    localparam payload_len_t REPLY_LEN = 6'd1;

    // ==========================================================================
    // Output configuration
    // ==========================================================================

    // Setup payload bits 4..2, handed on to the transmitters as is
    typedef logic [2:0] sample_rate_t;
    // Setup payload bits 1..0
    typedef logic [1:0] bit_depth_t;
    // Setup payload bits 7..6
    typedef logic [1:0] out_sel_t;

    // Upper selector bit set means S/PDIF, clear means I2S
    localparam int OUT_SEL_SPDIF_BIT = 1;

    // Status codes in the second reply byte
    typedef logic [7:0] error_code_t;

    localparam error_code_t ERROR_NONE             = 8'd0;
    localparam error_code_t ERROR_BAD_SETUP_LENGTH = 8'd1;
    localparam error_code_t ERROR_BAD_STOP_LENGTH  = 8'd2;

endpackage

`default_nettype wire

//--- design/host_fifo_reader.sv
`timescale 1ns/1ps
`default_nettype none

module host_fifo_reader
    import audio_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset_i,
    // Host input FIFO
    input  wire        in_empty_i,
    input  wire byte_t in_data_i,
    output logic       in_rd_o,
    // Parser side
    input  wire        accept_i,
    input  wire        sample_full_i,
    output logic       byte_valid_o,
    output byte_t      byte_data_o
);

    // Parser is reading and the output path has room
    logic  can_deliver;
    // Pop was issued last cycle, so its byte is on in_data_i now
    logic  inflight_q;
    // One byte parked because it arrived during a stall
    logic  held_q;
    byte_t held_data_q;

    assign can_deliver = accept_i && !sample_full_i;

    // Never pop while a byte is parked, it must go out first
    assign in_rd_o = can_deliver && !in_empty_i && !held_q;

    // Parked byte has priority over the FIFO read data
    assign byte_valid_o = can_deliver && (held_q || inflight_q);
    assign byte_data_o  = held_q ? held_data_q : in_data_i;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            inflight_q <= 1'b0;
            held_q     <= 1'b0;
        end else begin
            inflight_q <= in_rd_o;
            // Park the byte in flight on a stall, release once delivered
            held_q     <= (held_q || inflight_q) && !can_deliver;
        end
    end

    // Capture the read data in the cycle it would otherwise be lost
    always_ff @(posedge clk) begin
        if (inflight_q && !held_q && !can_deliver) begin
            held_data_q <= in_data_i;
        end
    end

    // A parked byte never has a pop beside it or a second byte behind it
    a_no_pop_while_held : assert property (
        @(posedge clk) disable iff (reset_i)
        held_q |-> (!in_rd_o && !inflight_q)
    );

endmodule

`default_nettype wire

//--- design/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser
    import audio_ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          reset_i,
    // Byte stream from the reader
    input  wire          byte_valid_i,
    input  wire byte_t   byte_data_i,
    output logic         accept_o,
    // Output path
    input  wire          streaming_i,
    output logic         sample_valid_o,
    output byte_t        sample_data_o,
    // Output configuration
    output logic         i2s_en_o,
    output logic         spdif_en_o,
    output sample_rate_t sample_rate_o,
    output bit_depth_t   bit_depth_o,
    // Status reply
    input  wire          reply_done_i,
    output logic         reply_start_o,
    output error_code_t  reply_code_o,
    output logic         err_o
);

    // ==========================================================================
    // State
    // ==========================================================================

    typedef enum logic {
        PROTO_HEADER,
        PROTO_PAYLOAD
    } proto_state_t;

    typedef enum logic [1:0] {
        PLAY_READ,
        PLAY_WAIT_STOP,
        PLAY_REPLY,
        PLAY_HALT
    } play_state_t;

    proto_state_t proto_q;
    play_state_t  play_q;
    payload_len_t remaining_q;
    cmd_t         last_cmd_q;
    // Set for error replies, the parser halts once the reply is out
    logic         halt_after_q;

    logic         hdr_valid;
    logic         pay_valid;
    logic         stream_byte;
    logic         stop_done;
    cmd_t         hdr_cmd;
    payload_len_t hdr_len;
    error_code_t  hdr_err;
    out_sel_t     out_sel;

    // ==========================================================================
    // Decode
    // ==========================================================================

    // Bytes are taken only in the reading state
    assign accept_o    = (play_q == PLAY_READ);
    assign hdr_valid   = byte_valid_i && accept_o && (proto_q == PROTO_HEADER);
    assign pay_valid   = byte_valid_i && accept_o && (proto_q == PROTO_PAYLOAD);
    assign stream_byte = pay_valid && (last_cmd_q == CMD_STREAM_OUTPUT);

    assign hdr_cmd = cmd_t'(byte_data_i[7:6]);
    assign hdr_len = byte_data_i[5:0];
    assign out_sel = byte_data_i[7:6];

    // Output path has drained after a stop
    assign stop_done = (play_q == PLAY_WAIT_STOP) && !streaming_i;

    // Length check for the commands that have a fixed payload
    always_comb begin
        hdr_err = ERROR_NONE;
        if (hdr_cmd == CMD_SETUP_OUTPUT && hdr_len != SETUP_PAYLOAD_LEN) begin
            hdr_err = ERROR_BAD_SETUP_LENGTH;
        end else if (hdr_cmd == CMD_STOP && hdr_len != STOP_PAYLOAD_LEN) begin
            hdr_err = ERROR_BAD_STOP_LENGTH;
        end
    end

    // ==========================================================================
    // Protocol FSM
    // ==========================================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            proto_q     <= PROTO_HEADER;
            remaining_q <= '0;
            last_cmd_q  <= CMD_SETUP_OUTPUT;
        end else if (hdr_valid) begin
            // Bad headers never open a payload, the parser halts anyway
            if (hdr_err == ERROR_NONE && hdr_len != '0) begin
                proto_q     <= PROTO_PAYLOAD;
                remaining_q <= hdr_len;
                last_cmd_q  <= hdr_cmd;
            end
        end else if (pay_valid) begin
            remaining_q <= remaining_q - 6'd1;
            // Last payload byte, next one is a header
            if (remaining_q == 6'd1) begin
                proto_q <= PROTO_HEADER;
            end
        end
    end

    // ==========================================================================
    // Playback FSM
    // ==========================================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            play_q        <= PLAY_READ;
            halt_after_q  <= 1'b0;
            reply_start_o <= 1'b0;
            err_o         <= 1'b0;
        end else begin
            reply_start_o <= 1'b0;
            unique case (play_q)
                PLAY_READ: begin
                    if (hdr_valid && hdr_err != ERROR_NONE) begin
                        play_q        <= PLAY_REPLY;
                        reply_start_o <= 1'b1;
                        halt_after_q  <= 1'b1;
                        err_o         <= 1'b1;
                    end else if (hdr_valid && hdr_cmd == CMD_STOP) begin
                        play_q <= PLAY_WAIT_STOP;
                    end
                end
                PLAY_WAIT_STOP: begin
                    if (stop_done) begin
                        play_q        <= PLAY_REPLY;
                        reply_start_o <= 1'b1;
                        halt_after_q  <= 1'b0;
                    end
                end
                PLAY_REPLY: begin
                    if (reply_done_i) begin
                        play_q <= halt_after_q ? PLAY_HALT : PLAY_READ;
                    end
                end
                PLAY_HALT: begin
                    // Only a reset leaves this state
                    play_q <= PLAY_HALT;
                end
            endcase
        end
    end

    // ==========================================================================
    // Configuration and samples
    // ==========================================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            sample_valid_o <= 1'b0;
            i2s_en_o       <= 1'b0;
            spdif_en_o     <= 1'b0;
            sample_rate_o  <= '0;
            bit_depth_o    <= '0;
        end else begin
            sample_valid_o <= stream_byte;
            // Setup-input payload falls through here and is dropped
            if (pay_valid && last_cmd_q == CMD_SETUP_OUTPUT) begin
                spdif_en_o    <= out_sel[OUT_SEL_SPDIF_BIT];
                i2s_en_o      <= !out_sel[OUT_SEL_SPDIF_BIT];
                sample_rate_o <= byte_data_i[4:2];
                bit_depth_o   <= byte_data_i[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stream_byte) begin
            sample_data_o <= byte_data_i;
        end
        // Code is set in the same cycle that reply_start_o is raised
        if (hdr_valid && hdr_err != ERROR_NONE) begin
            reply_code_o <= hdr_err;
        end else if (stop_done) begin
            reply_code_o <= ERROR_NONE;
        end
    end

    a_sample_only_reading : assert property (
        @(posedge clk) disable iff (reset_i)
        sample_valid_o |-> (play_q == PLAY_READ)
    );

    a_start_only_replying : assert property (
        @(posedge clk) disable iff (reset_i)
        reply_start_o |-> (play_q == PLAY_REPLY)
    );

endmodule

`default_nettype wire

//--- design/status_reply_writer.sv
`timescale 1ns/1ps
`default_nettype none

module status_reply_writer
    import audio_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset_i,
    // From the parser
    input  wire        reply_start_i,
    input  wire byte_t reply_code_i,
    output logic       reply_done_o,
    // Host output FIFO
    input  wire        reply_full_i,
    output logic       reply_wr_o,
    output byte_t      reply_data_o
);

    // Stopped command with a one-byte payload
    localparam byte_t REPLY_HEADER = {CMD_STOP, REPLY_LEN};

    logic  busy_q;
    // Low for the header byte, high for the status code
    logic  byte_idx_q;
    byte_t code_q;

    // Write straight from the full flag so a full FIFO is never written
    assign reply_wr_o   = busy_q && !reply_full_i;
    assign reply_data_o = byte_idx_q ? code_q : REPLY_HEADER;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            byte_idx_q   <= 1'b0;
            reply_done_o <= 1'b0;
        end else begin
            reply_done_o <= 1'b0;
            if (reply_start_i) begin
                busy_q     <= 1'b1;
                byte_idx_q <= 1'b0;
            end else if (reply_wr_o) begin
                if (byte_idx_q) begin
                    // Code byte accepted, reply complete
                    busy_q       <= 1'b0;
                    byte_idx_q   <= 1'b0;
                    reply_done_o <= 1'b1;
                end else begin
                    byte_idx_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reply_start_i) begin
            code_q <= reply_code_i;
        end
    end

    a_no_write_when_full : assert property (
        @(posedge clk) disable iff (reset_i)
        reply_wr_o |-> !reply_full_i
    );

    // Parser waits for reply_done_o before it can start another reply
    a_no_start_while_busy : assert property (
        @(posedge clk) disable iff (reset_i)
        reply_start_i |-> !busy_q
    );

endmodule

`default_nettype wire

//--- design/audio_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module audio_ctrl
    import audio_ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          reset_i,
    // Host input FIFO
    input  wire          in_empty_i,
    input  wire byte_t   in_data_i,
    output logic         in_rd_o,
    // Audio output path
    input  wire          sample_full_i,
    input  wire          streaming_i,
    output logic         sample_valid_o,
    output byte_t        sample_data_o,
    // Host output FIFO
    input  wire          reply_full_i,
    output logic         reply_wr_o,
    output byte_t        reply_data_o,
    // Configuration and status
    output logic         i2s_en_o,
    output logic         spdif_en_o,
    output sample_rate_t sample_rate_o,
    output bit_depth_t   bit_depth_o,
    output logic         err_o
);

    // Reader to parser
    logic        byte_valid;
    byte_t       byte_data;
    logic        accept;

    // Parser to writer
    logic        reply_start;
    error_code_t reply_code;
    logic        reply_done;

    // ==========================================================================
    // Input side
    // ==========================================================================

    host_fifo_reader host_fifo_reader_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_empty_i    (in_empty_i),
        .in_data_i     (in_data_i),
        .in_rd_o       (in_rd_o),
        .accept_i      (accept),
        .sample_full_i (sample_full_i),
        .byte_valid_o  (byte_valid),
        .byte_data_o   (byte_data)
    );

    // Header and payload handling, playback control
    cmd_parser cmd_parser_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .byte_valid_i   (byte_valid),
        .byte_data_i    (byte_data),
        .accept_o       (accept),
        .streaming_i    (streaming_i),
        .sample_valid_o (sample_valid_o),
        .sample_data_o  (sample_data_o),
        .i2s_en_o       (i2s_en_o),
        .spdif_en_o     (spdif_en_o),
        .sample_rate_o  (sample_rate_o),
        .bit_depth_o    (bit_depth_o),
        .reply_done_i   (reply_done),
        .reply_start_o  (reply_start),
        .reply_code_o   (reply_code),
        .err_o          (err_o)
    );

    // ==========================================================================
    // Output side
    // ==========================================================================

    status_reply_writer status_reply_writer_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .reply_start_i (reply_start),
        .reply_code_i  (reply_code),
        .reply_done_o  (reply_done),
        .reply_full_i  (reply_full_i),
        .reply_wr_o    (reply_wr_o),
        .reply_data_o  (reply_data_o)
    );

endmodule

`default_nettype wire

//--- tb/audio_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_ctrl_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 16;
    // Output path keeps playing this long after a stop header is pushed
    localparam int STREAM_HOLD     = 40;
    // Idle time after a test so stray outputs still get caught
    localparam int SETTLE_CYCLES   = 20;
    localparam int CYCLES_PER_LINE = 200;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       in_empty_i;
    logic [7:0] in_data_i;
    logic       in_rd_o;
    logic       sample_full_i;
    logic       streaming_i;
    logic       sample_valid_o;
    logic [7:0] sample_data_o;
    logic       reply_full_i;
    logic       reply_wr_o;
    logic [7:0] reply_data_o;
    logic       i2s_en_o;
    logic       spdif_en_o;
    logic [2:0] sample_rate_o;
    logic [1:0] bit_depth_o;
    logic       err_o;

    // Vector lines, then the current test's stimulus and expectations
    string      tags[$];
    logic [31:0] vals[$];
    int         n_lines = 0;
    logic [7:0] push_q[$];
    logic [7:0] fifo_q[$];
    logic [7:0] exp_sample_q[$];
    logic [7:0] exp_reply_q[$];
    logic [6:0] exp_cfg_q[$];
    logic       exp_err;

    int          errors = 0;
    int          reset_left = 0;
    int          stream_left = 0;
    // Payload bytes still to come before the next header in the pushed stream
    int          hdr_left = 0;
    logic        pop_seen = 1'b0;
    logic        full_prev = 1'b0;
    logic [31:0] rnd = 32'd97;
    logic [6:0]  cfg_prev = '0;
    logic [6:0]  cur_cfg;

    // Configuration as one word, i2s and spdif enables above rate and depth
    assign cur_cfg = {i2s_en_o, spdif_en_o, sample_rate_o, bit_depth_o};

    audio_ctrl audio_ctrl_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .in_empty_i     (in_empty_i),
        .in_data_i      (in_data_i),
        .in_rd_o        (in_rd_o),
        .sample_full_i  (sample_full_i),
        .streaming_i    (streaming_i),
        .sample_valid_o (sample_valid_o),
        .sample_data_o  (sample_data_o),
        .reply_full_i   (reply_full_i),
        .reply_wr_o     (reply_wr_o),
        .reply_data_o   (reply_data_o),
        .i2s_en_o       (i2s_en_o),
        .spdif_en_o     (spdif_en_o),
        .sample_rate_o  (sample_rate_o),
        .bit_depth_o    (bit_depth_o),
        .err_o          (err_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        reset_i       = 1'b1;
        in_empty_i    = 1'b1;
        in_data_i     = 8'h00;
        sample_full_i = 1'b0;
        streaming_i   = 1'b0;
        reply_full_i  = 1'b0;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        errors++;
    endtask

    // All expected outputs seen and the stimulus used up, or the DUT halted
    function automatic logic test_done();
        return reset_left == 0 && !reset_i
            && ((push_q.size() == 0 && fifo_q.size() == 0) || err_o)
            && stream_left == 0
            && exp_sample_q.size() == 0 && exp_reply_q.size() == 0
            && exp_cfg_q.size() == 0;
    endfunction

    // ==========================================================================
    // Host FIFO, output path and reset models
    // ==========================================================================

    always @(posedge clk) begin : drive_inputs
        logic [7:0] b;
        #(DRIVE_DELAY);
        rnd           = xorshift(rnd);
        sample_full_i = rnd[4];
        reply_full_i  = rnd[9];
        if (reset_left > 0) begin
            reset_i     = 1'b1;
            reset_left  = reset_left - 1;
            stream_left = 0;
            hdr_left    = 0;
            fifo_q.delete();
        end else begin
            reset_i = 1'b0;
            // One-cycle read latency, pop seen last cycle shows up now
            if (pop_seen) begin
                if (fifo_q.size() == 0) begin
                    report_error("DUT popped the host input FIFO while it was empty");
                end else begin
                    in_data_i = fifo_q.pop_front();
                end
            end
            if (stream_left > 0) begin
                stream_left = stream_left - 1;
            end
            // Keep the FIFO shallow so the DUT reaches a stop header quickly
            if (push_q.size() > 0 && fifo_q.size() < 2) begin
                b = push_q.pop_front();
                fifo_q.push_back(b);
                if (hdr_left == 0) begin
                    // Legal stop header, audio keeps playing for a while
                    if (b == 8'hc0) begin
                        stream_left = STREAM_HOLD;
                    end
                    hdr_left = int'(b[5:0]);
                end else begin
                    hdr_left = hdr_left - 1;
                end
            end
        end
        streaming_i = (stream_left != 0);
        in_empty_i  = (fifo_q.size() == 0);
    end

    // ==========================================================================
    // Output checks, sampled mid-cycle
    // ==========================================================================

    always @(negedge clk) begin : check_outputs
        logic [7:0] exp_byte;
        logic [6:0] exp_cfg;
        pop_seen = in_rd_o;
        if (reset_i) begin
            cfg_prev  = cur_cfg;
            full_prev = sample_full_i;
        end else begin
            if (sample_valid_o) begin
                // Byte behind this sample was delivered last cycle
                if (full_prev) begin
                    report_error("sample delivered while sample_full_i was high");
                end
                if (exp_sample_q.size() == 0) begin
                    report_error($sformatf("unexpected sample 0x%02h", sample_data_o));
                end else begin
                    exp_byte = exp_sample_q.pop_front();
                    if (sample_data_o !== exp_byte) begin
                        report_error($sformatf("sample 0x%02h, expected 0x%02h",
                            sample_data_o, exp_byte));
                    end
                end
            end
            if (reply_wr_o) begin
                if (reply_full_i) begin
                    report_error("reply byte written while reply_full_i was high");
                end
                if (streaming_i) begin
                    report_error("reply written while the output was still streaming");
                end
                if (exp_reply_q.size() == 0) begin
                    report_error($sformatf("unexpected reply byte 0x%02h", reply_data_o));
                end else begin
                    exp_byte = exp_reply_q.pop_front();
                    if (reply_data_o !== exp_byte) begin
                        report_error($sformatf("reply byte 0x%02h, expected 0x%02h",
                            reply_data_o, exp_byte));
                    end
                end
            end
            if (cur_cfg !== cfg_prev) begin
                if (exp_cfg_q.size() == 0) begin
                    report_error($sformatf("unexpected configuration 0x%02h", cur_cfg));
                end else begin
                    exp_cfg = exp_cfg_q.pop_front();
                    if (cur_cfg !== exp_cfg) begin
                        report_error($sformatf("configuration 0x%02h, expected 0x%02h",
                            cur_cfg, exp_cfg));
                    end
                end
                cfg_prev = cur_cfg;
            end
            full_prev = sample_full_i;
        end
    end

    initial begin : watchdog
        wait (n_lines > 0);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", n_lines * CYCLES_PER_LINE);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==========================================================================
    // Test sequencing
    // ==========================================================================

    initial begin : run_tests
        int          fd;
        string       line;
        string       tag;
        logic [31:0] val;
        int          idx;
        int          test_id;
        int          errors_before;
        int          tests_run;
        int          tests_failed;
        idx          = 0;
        tests_run    = 0;
        tests_failed = 0;
        fd = $fopen("tb/audio_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file tb/audio_ctrl_vectors.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h", tag, val) == 2) begin
                        tags.push_back(tag);
                        vals.push_back(val);
                    end
                end
            end
            $fclose(fd);
            n_lines = tags.size();
            while (idx < n_lines) begin
                // Every test opens with a reset line carrying its number
                if (tags[idx] != "reset") begin
                    report_error($sformatf("vector line %0d does not start a test", idx));
                end
                test_id = int'(vals[idx]);
                idx++;
                @(posedge clk);
                push_q.delete();
                exp_sample_q.delete();
                exp_reply_q.delete();
                exp_cfg_q.delete();
                exp_err       = 1'b0;
                errors_before = errors;
                while (idx < n_lines && tags[idx] != "reset") begin
                    if (tags[idx] == "push") begin
                        push_q.push_back(vals[idx][7:0]);
                    end else if (tags[idx] == "sample") begin
                        exp_sample_q.push_back(vals[idx][7:0]);
                    end else if (tags[idx] == "reply") begin
                        exp_reply_q.push_back(vals[idx][7:0]);
                    end else if (tags[idx] == "config") begin
                        exp_cfg_q.push_back(vals[idx][6:0]);
                    end else if (tags[idx] == "error") begin
                        exp_err = vals[idx][0];
                    end else begin
                        report_error($sformatf("unknown tag %s on vector line %0d",
                            tags[idx], idx));
                    end
                    idx++;
                end
                reset_left = RESET_CYCLES;
                @(posedge clk);
                while (!test_done()) begin
                    @(posedge clk);
                end
                repeat (SETTLE_CYCLES) @(posedge clk);
                if (err_o !== exp_err) begin
                    report_error($sformatf("err_o is %b, expected %b", err_o, exp_err));
                end
                tests_run++;
                if (errors != errors_before) begin
                    tests_failed++;
                end
                $display("test %0d: %s, %0d errors", test_id,
                    (errors == errors_before) ? "ok" : "failed", errors - errors_before);
            end
            $display("tests run %0d, tests failed %0d, errors %0d",
                tests_run, tests_failed, errors);
            if (errors == 0 && tests_run > 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/audio_ctrl_vectors.txt
# Columns are tag and hex value. push is a byte into the host input FIFO, sample and reply
# are expected output bytes, config is {i2s, spdif, rate, depth}, error is err_o, reset n
reset 1
push 01
push 96
config 36
push 01
push 0d
config 4d
reset 2
push 83
push 5a
push a5
push 3c
sample 5a
sample a5
sample 3c
push c0
reply c1
reply 00
push 82
push 7e
push 81
sample 7e
sample 81
reset 3
push c2
push 10
push 82
push 11
push 22
reply c1
reply 02
error 1
reset 4
push 41
push 55
push 02
push 96
push 00
reply c1
reply 01
error 1

//--- tb.f
design/audio_ctrl_pkg.sv
design/host_fifo_reader.sv
design/cmd_parser.sv
design/status_reply_writer.sv
design/audio_ctrl.sv
tb/audio_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the audio_ctrl testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module audio_ctrl_tb -f tb.f -o audio_ctrl_tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/audio_ctrl_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
